//--- flist.f
+incdir+tb
common/fp_format_pkg.sv
common/fpu_ctrl_pkg.sv
fpu_misc/fp_unpack.sv
fpu_misc/fp_compare.sv
fpu_misc/fp_sign_class.sv
src/fpu_misc_unit.sv
tb/tb_clock_gen.sv
tb/fpu_misc_tb.sv

//--- tb/fpu_misc_vectors.svh
// directed vectors, included inside fpu_misc_tb after the package imports
// singles are boxed by the helpers, add_raw takes operands exactly as given
`ifndef FPU_MISC_VECTORS_SVH
`define FPU_MISC_VECTORS_SVH

typedef struct packed {
	fpu_cmd_t   cmd;
	fp_word_t   fr1;
	fp_word_t   fr2;
	xlen_word_t ir1;
	fp_word_t   exp_value;
	logic       exp_wfp;
	fp_flags_t  exp_flags;
} vec_t;

vec_t  vecs[$];
string vec_names[$];

// double operands
localparam fp_word_t D_ONE     = 64'h3ff0000000000000;
localparam fp_word_t D_TWO     = 64'h4000000000000000;
localparam fp_word_t D_NEG_ONE = 64'hbff0000000000000;
localparam fp_word_t D_NEG_TWO = 64'hc000000000000000;
localparam fp_word_t D_PZERO   = 64'h0000000000000000;
localparam fp_word_t D_NZERO   = 64'h8000000000000000;
localparam fp_word_t D_PINF    = 64'h7ff0000000000000;
localparam fp_word_t D_NINF    = 64'hfff0000000000000;
localparam fp_word_t D_QNAN    = 64'h7ff8000000000000;
localparam fp_word_t D_SNAN    = 64'h7ff4000000000000;
localparam fp_word_t D_PSUB    = 64'h0000000000000001;
localparam fp_word_t D_NSUB    = 64'h8000000000000001;

task automatic add_raw(input string name, input fpu_op_t op, input fp_fmt_t fmt,
		input logic [2:0] sub, input logic from_int, input fp_word_t a, input fp_word_t b,
		input xlen_word_t i, input fp_word_t exp_value, input logic wfp, input logic nv);
	vec_t v;
	v.cmd.op = op;
	v.cmd.fmt = fmt;
	v.cmd.sub = sub;
	v.cmd.from_int = from_int;
	v.cmd.rd = TAG_W_DEFAULT'(vecs.size());	// tag follows the entry number
	v.fr1 = a;
	v.fr2 = b;
	v.ir1 = i;
	v.exp_value = exp_value;
	v.exp_wfp = wfp;
	v.exp_flags = '0;
	v.exp_flags.nv = nv;
	vecs.push_back(v);
	vec_names.push_back(name);
endtask

// single result going to the integer file
task automatic add_s_int(input string name, input fpu_op_t op, input logic [2:0] sub,
		input logic [31:0] a, input logic [31:0] b, input fp_word_t exp_value, input logic nv);
	add_raw(name, op, FMT_S, sub, 1'b0, {32'hffffffff, a}, {32'hffffffff, b}, '0,
		exp_value, 1'b0, nv);
endtask

// single result going to the FP file, expected value comes back boxed
task automatic add_s_fp(input string name, input fpu_op_t op, input logic [2:0] sub,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp_s, input logic nv);
	add_raw(name, op, FMT_S, sub, 1'b0, {32'hffffffff, a}, {32'hffffffff, b}, '0,
		{32'hffffffff, exp_s}, 1'b1, nv);
endtask

task automatic add_d(input string name, input fpu_op_t op, input logic [2:0] sub,
		input fp_word_t a, input fp_word_t b, input fp_word_t exp_value, input logic wfp,
		input logic nv);
	add_raw(name, op, FMT_D, sub, 1'b0, a, b, '0, exp_value, wfp, nv);
endtask

task automatic load_vectors();
	// sign injection
	add_s_fp("sgnj_s", OP_SGN, SUB_SGNJ, 32'h3f800000, 32'hc0000000, 32'hbf800000, 0);
	add_s_fp("sgnjn_s", OP_SGN, SUB_SGNJN, 32'hbf800000, 32'hc0000000, 32'h3f800000, 0);
	add_s_fp("sgnjx_s", OP_SGN, SUB_SGNJX, 32'hbf800000, 32'h40000000, 32'hbf800000, 0);
	add_d("sgnj_d", OP_SGN, SUB_SGNJ, D_ONE, D_NEG_TWO, D_NEG_ONE, 1, 0);
	add_d("sgnjn_d", OP_SGN, SUB_SGNJN, D_NEG_ONE, D_NEG_ONE, D_ONE, 1, 0);
	add_d("sgnjx_d", OP_SGN, SUB_SGNJX, D_NEG_ONE, D_TWO, D_NEG_ONE, 1, 0);
	// compares, nv on any NaN for le/lt, only on sNaN for eq
	add_s_int("fle_s_lt", OP_CMP, SUB_LE, 32'h3f800000, 32'h40000000, 1, 0);
	add_s_int("flt_s_gt", OP_CMP, SUB_LT, 32'h40000000, 32'h3f800000, 0, 0);
	add_s_int("flt_s_neg", OP_CMP, SUB_LT, 32'hbf800000, 32'h3f800000, 1, 0);
	add_s_int("feq_s_zero", OP_CMP, SUB_EQ, 32'h80000000, 32'h00000000, 1, 0);
	add_s_int("flt_s_zero", OP_CMP, SUB_LT, 32'h80000000, 32'h00000000, 0, 0);
	add_s_int("flt_s_inf", OP_CMP, SUB_LT, 32'hff800000, 32'h7f800000, 1, 0);
	add_s_int("feq_s_qnan", OP_CMP, SUB_EQ, 32'h7fc00000, 32'h3f800000, 0, 0);
	add_s_int("feq_s_snan", OP_CMP, SUB_EQ, 32'h7fa00000, 32'h3f800000, 0, 1);
	add_s_int("flt_s_qnan", OP_CMP, SUB_LT, 32'h3f800000, 32'h7fc00000, 0, 1);
	add_s_int("fle_s_qnan", OP_CMP, SUB_LE, 32'h7fc00000, 32'h7fc00000, 0, 1);
	add_d("flt_d_neg", OP_CMP, SUB_LT, D_NEG_TWO, D_NEG_ONE, 1, 0, 0);
	add_d("feq_d_zero", OP_CMP, SUB_EQ, D_NZERO, D_PZERO, 1, 0, 0);
	add_d("fle_d_inf", OP_CMP, SUB_LE, D_NINF, D_TWO, 1, 0, 0);
	add_d("feq_d_snan", OP_CMP, SUB_EQ, D_SNAN, D_SNAN, 0, 0, 1);
	// min and max, two-NaN operands are not canonical so the result must be rebuilt
	add_s_fp("min_s", OP_MINMAX, SUB_MIN, 32'h3f800000, 32'h40000000, 32'h3f800000, 0);
	add_s_fp("max_s", OP_MINMAX, SUB_MAX, 32'h3f800000, 32'h40000000, 32'h40000000, 0);
	add_s_fp("min_s_zero", OP_MINMAX, SUB_MIN, 32'h00000000, 32'h80000000, 32'h80000000, 0);
	add_s_fp("min_s_qnan", OP_MINMAX, SUB_MIN, 32'h7fc00000, 32'hbf800000, 32'hbf800000, 0);
	add_s_fp("max_s_2nan", OP_MINMAX, SUB_MAX, 32'hffc00001, 32'h7fa00000, 32'h7fc00000, 1);
	add_s_fp("min_s_snan", OP_MINMAX, SUB_MIN, 32'h3f800000, 32'h7fa00000, 32'h3f800000, 1);
	add_d("max_d_neg", OP_MINMAX, SUB_MAX, D_NEG_TWO, D_NEG_ONE, D_NEG_ONE, 1, 0);
	add_d("min_d_zero", OP_MINMAX, SUB_MIN, D_PZERO, D_NZERO, D_NZERO, 1, 0);
	add_d("max_d_2nan", OP_MINMAX, SUB_MAX, 64'hfff8000000000001, D_SNAN, D_QNAN, 1, 1);
	// FCLASS, one of each class
	add_s_int("class_s_ninf", OP_CLASS, 0, 32'hff800000, 32'h0, 'h001, 0);
	add_s_int("class_s_nnorm", OP_CLASS, 0, 32'hbf800000, 32'h0, 'h002, 0);
	add_s_int("class_s_nsub", OP_CLASS, 0, 32'h80000001, 32'h0, 'h004, 0);
	add_s_int("class_s_nzero", OP_CLASS, 0, 32'h80000000, 32'h0, 'h008, 0);
	add_s_int("class_s_pzero", OP_CLASS, 0, 32'h00000000, 32'h0, 'h010, 0);
	add_s_int("class_s_psub", OP_CLASS, 0, 32'h00000001, 32'h0, 'h020, 0);
	add_s_int("class_s_pnorm", OP_CLASS, 0, 32'h3f800000, 32'h0, 'h040, 0);
	add_s_int("class_s_pinf", OP_CLASS, 0, 32'h7f800000, 32'h0, 'h080, 0);
	add_s_int("class_s_snan", OP_CLASS, 0, 32'h7fa00000, 32'h0, 'h100, 0);
	add_s_int("class_s_qnan", OP_CLASS, 0, 32'h7fc00000, 32'h0, 'h200, 0);
	add_d("class_d_ninf", OP_CLASS, 0, D_NINF, D_PZERO, 'h001, 0, 0);
	add_d("class_d_nnorm", OP_CLASS, 0, D_NEG_ONE, D_PZERO, 'h002, 0, 0);
	add_d("class_d_nsub", OP_CLASS, 0, D_NSUB, D_PZERO, 'h004, 0, 0);
	add_d("class_d_nzero", OP_CLASS, 0, D_NZERO, D_PZERO, 'h008, 0, 0);
	add_d("class_d_pzero", OP_CLASS, 0, D_PZERO, D_PZERO, 'h010, 0, 0);
	add_d("class_d_psub", OP_CLASS, 0, D_PSUB, D_PZERO, 'h020, 0, 0);
	add_d("class_d_pnorm", OP_CLASS, 0, D_ONE, D_PZERO, 'h040, 0, 0);
	add_d("class_d_pinf", OP_CLASS, 0, D_PINF, D_PZERO, 'h080, 0, 0);
	add_d("class_d_snan", OP_CLASS, 0, D_SNAN, D_PZERO, 'h100, 0, 0);
	add_d("class_d_qnan", OP_CLASS, 0, D_QNAN, D_PZERO, 'h200, 0, 0);
	add_raw("class_s_unboxed", OP_CLASS, FMT_S, 0, 1'b0, 64'h000000003f800000, '0, '0,
		'h200, 0, 0);
	// moves, to-int sign-extends, from-int boxes
	add_raw("fmv_x_w_neg", OP_MV, FMT_S, 0, 1'b0, 64'h00000000c0000000, '0, '0,
		64'hffffffffc0000000, 0, 0);
	add_raw("fmv_x_w_pos", OP_MV, FMT_S, 0, 1'b0, 64'hffffffff3f800000, '0, '0,
		64'h000000003f800000, 0, 0);
	add_raw("fmv_x_d", OP_MV, FMT_D, 0, 1'b0, 64'h0123456789abcdef, '0, '0,
		64'h0123456789abcdef, 0, 0);
	add_raw("fmv_w_x", OP_MV, FMT_S, 0, 1'b1, '0, '0, 64'h123456783f800000,
		64'hffffffff3f800000, 1, 0);
	add_raw("fmv_d_x", OP_MV, FMT_D, 0, 1'b1, '0, '0, D_NEG_TWO, D_NEG_TWO, 1, 0);
endtask

`endif

//--- tb/fpu_misc_tb.sv
// directed table, then random back-to-back sign injection with a fixed latency of 2
// inputs change on the falling edge, outputs are read on the falling edge
`timescale 1ns/1ps

module fpu_misc_tb import fp_format_pkg::*, fpu_ctrl_pkg::*; ();

	localparam int VALID_TIMEOUT = 10;
	localparam int RESET_TIMEOUT = 20;
	localparam int RAND_OPS      = 16;
	localparam int LATENCY       = 2;

	logic        clk;
	logic        rst_n;
	logic        enable;
	fpu_cmd_t    cmd;
	fp_word_t    fr1;
	fp_word_t    fr2;
	xlen_word_t  ir1;
	fpu_result_t result;

	fp_word_t                 pipe_value [RAND_OPS];
	logic [TAG_W_DEFAULT-1:0] pipe_rd [RAND_OPS];

	`include "fpu_misc_vectors.svh"

	tb_clock_gen clock_gen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	fpu_misc_unit #(
		.TAG_W (TAG_W_DEFAULT)
	) fpu_misc_unit_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.enable (enable),
		.cmd    (cmd),
		.fr1    (fr1),
		.fr2    (fr2),
		.ir1    (ir1),
		.result (result)
	);

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected)
			stop_failed($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
	endtask

	// reference sign injection from the ISA rule
	function automatic fp_word_t expect_sign_inject(input fp_fmt_t fmt, input logic [2:0] sub,
			input fp_word_t a, input fp_word_t b);
		int       sp;
		logic     s;
		fp_word_t r;
		sp = (fmt == FMT_D) ? 63 : 31;
		case (sub)
			SUB_SGNJN: s = ~b[sp];
			SUB_SGNJX: s = a[sp] ^ b[sp];
			default:   s = b[sp];
		endcase
		r = a;
		r[sp] = s;
		if (fmt == FMT_S)
			r[63:32] = '1;
		return r;
	endfunction

	task automatic wait_result_valid(input string name);
		int cycles;
		cycles = 0;
		while (result.valid !== 1'b1) begin
			if (cycles == VALID_TIMEOUT) begin
				stop_failed($sformatf("timeout: no valid result for %s within %0d cycles",
					name, VALID_TIMEOUT));
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	task automatic check_reset();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!rst_n) begin
			check_value("reset valid", 0, 64'(result.valid));
			if (cycles == RESET_TIMEOUT) begin
				stop_failed("timeout: reset was never released");
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
		repeat (3) begin	// idle, enable low
			@(negedge clk);
			check_value("post-reset valid", 0, 64'(result.valid));
		end
	endtask

	task automatic run_table();
		vec_t  v;
		string name;
		for (int i = 0; i < vecs.size(); i++) begin
			v = vecs[i];
			name = vec_names[i];
			@(negedge clk);
			check_value({name, " idle valid"}, 0, 64'(result.valid));	// one-cycle pulse
			cmd = v.cmd;
			fr1 = v.fr1;
			fr2 = v.fr2;
			ir1 = v.ir1;
			enable = 1'b1;
			@(negedge clk);
			enable = 1'b0;
			wait_result_valid(name);
			check_value({name, " value"}, v.exp_value, result.value);
			check_value({name, " rd"}, 64'(v.cmd.rd), 64'(result.rd));
			check_value({name, " writes_fp"}, 64'(v.exp_wfp), 64'(result.writes_fp));
			check_value({name, " flags"}, 64'(v.exp_flags), 64'(result.flags));
		end
	endtask

	// one op per cycle, each result must show up exactly LATENCY edges later
	task automatic run_back_to_back();
		fp_fmt_t    fmt;
		logic [2:0] sub;
		fp_word_t   a;
		fp_word_t   b;
		string      name;
		for (int k = 0; k < RAND_OPS + LATENCY; k++) begin
			@(negedge clk);
			if (k >= LATENCY) begin
				name = $sformatf("b2b_%0d", k - LATENCY);
				check_value({name, " valid"}, 1, 64'(result.valid));
				check_value({name, " value"}, pipe_value[k - LATENCY], result.value);
				check_value({name, " rd"}, 64'(pipe_rd[k - LATENCY]), 64'(result.rd));
				check_value({name, " writes_fp"}, 1, 64'(result.writes_fp));
				check_value({name, " flags"}, 0, 64'(result.flags));
			end else begin
				check_value($sformatf("b2b_lead_%0d valid", k), 0, 64'(result.valid));
			end
			if (k < RAND_OPS) begin
				fmt = fp_fmt_t'($urandom_range(0, 1));
				sub = 3'($urandom_range(0, 2));
				a = {$urandom, $urandom};
				b = {$urandom, $urandom};
				if (fmt == FMT_S) begin
					a[63:32] = '1;
					b[63:32] = '1;
				end
				cmd.op = OP_SGN;
				cmd.fmt = fmt;
				cmd.sub = sub;
				cmd.from_int = 1'b0;
				cmd.rd = TAG_W_DEFAULT'($urandom_range(0, 31));
				fr1 = a;
				fr2 = b;
				ir1 = {$urandom, $urandom};
				enable = 1'b1;
				pipe_value[k] = expect_sign_inject(fmt, sub, a, b);
				pipe_rd[k] = cmd.rd;
			end else begin
				enable = 1'b0;
			end
		end
		@(negedge clk);
		check_value("b2b_drain valid", 0, 64'(result.valid));
	endtask

	initial begin
		enable = 1'b0;
		cmd = '0;
		fr1 = '0;
		fr2 = '0;
		ir1 = '0;
		void'($urandom(71609));
		load_vectors();
		check_reset();
		run_table();
		run_back_to_back();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- tb/tb_clock_gen.sv
// testbench clock and reset source, 100 ns period
// rst_n is released on a falling edge after 10 rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD = 50,
	parameter int RST_CYCLES  = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;	// nonblocking, so negedge samplers still see reset this edge
	end

endmodule

//--- src/fpu_misc_unit.sv
// two-stage pipe: issue register, then write-back register, result 2 edges after issue
// no back-pressure, one op per clock, rd width is fixed by the package structs
`timescale 1ns/1ps

module fpu_misc_unit import fp_format_pkg::*, fpu_ctrl_pkg::*; #(
	parameter int TAG_W = TAG_W_DEFAULT
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        enable,
	input  fpu_cmd_t    cmd,
	input  fp_word_t    fr1,
	input  fp_word_t    fr2,
	input  xlen_word_t  ir1,
	output fpu_result_t result
);

	// structs carry the default tag width
	if (TAG_W != TAG_W_DEFAULT) begin : g_tag_check
		$error("fpu_misc_unit: TAG_W must equal TAG_W_DEFAULT");
	end

	logic       iss_valid;
	fpu_cmd_t   iss_cmd;
	fp_word_t   iss_fr1;
	fp_word_t   iss_fr2;
	xlen_word_t iss_ir1;

	fp_unpacked_t opnd_a;
	fp_unpacked_t opnd_b;
	fp_word_t     cmp_value;
	fp_flags_t    cmp_flags;
	fp_word_t     sc_value;
	fp_word_t     wb_value;
	fp_flags_t    wb_flags;
	logic         wb_writes_fp;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			iss_valid <= 1'b0;
		end else begin
			iss_valid <= enable;
		end
		if (enable) begin	// payload held while idle
			iss_cmd <= cmd;
			iss_fr1 <= fr1;
			iss_fr2 <= fr2;
			iss_ir1 <= ir1;
		end
	end

	fp_unpack fp_unpack_a_inst (
		.value (iss_fr1),
		.fmt   (iss_cmd.fmt),
		.opnd  (opnd_a)
	);

	fp_unpack fp_unpack_b_inst (
		.value (iss_fr2),
		.fmt   (iss_cmd.fmt),
		.opnd  (opnd_b)
	);

	fp_compare fp_compare_inst (
		.a         (opnd_a),
		.b         (opnd_b),
		.raw_a     (iss_fr1),
		.raw_b     (iss_fr2),
		.fmt       (iss_cmd.fmt),
		.sub       (iss_cmd.sub),
		.is_minmax (iss_cmd.op == OP_MINMAX),
		.value     (cmp_value),
		.flags     (cmp_flags)
	);

	fp_sign_class fp_sign_class_inst (
		.a        (opnd_a),
		.raw_a    (iss_fr1),
		.raw_b    (iss_fr2),
		.int_in   (iss_ir1),
		.fmt      (iss_cmd.fmt),
		.sub      (iss_cmd.sub),
		.op       (iss_cmd.op),
		.from_int (iss_cmd.from_int),
		.value    (sc_value)
	);

	always_comb begin
		wb_value = sc_value;
		wb_flags = '0;	// only compare and min/max raise nv
		wb_writes_fp = 1'b0;
		case (iss_cmd.op)
			OP_SGN: begin
				wb_writes_fp = 1'b1;
			end
			OP_MINMAX: begin
				wb_value = cmp_value;
				wb_flags = cmp_flags;
				wb_writes_fp = 1'b1;
			end
			OP_CMP: begin
				wb_value = cmp_value;
				wb_flags = cmp_flags;
			end
			OP_MV: wb_writes_fp = iss_cmd.from_int;
			OP_CLASS: wb_writes_fp = 1'b0;	// mask goes to the integer file
			default: wb_value = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= iss_valid;
		end
		result.value <= wb_value;
		result.rd <= iss_cmd.rd;
		result.writes_fp <= wb_writes_fp;
		result.flags <= wb_flags;
	end

	a_op_kept: assert property (@(posedge clk) disable iff (!rst_n)
		enable |-> cmd.op inside {OP_SGN, OP_MINMAX, OP_CMP, OP_CLASS, OP_MV})
		else $error("fpu_misc_unit: issued op is not handled by this unit");

	// every single written to the FP file leaves boxed, whichever module made it
	a_s_boxed: assert property (@(posedge clk) disable iff (!rst_n)
		iss_valid && (iss_cmd.fmt == FMT_S) && wb_writes_fp |-> &wb_value[D_SIGN_POS:BOX_LSB])
		else $error("fpu_misc_unit: single result for the FP file is not NaN-boxed");

endmodule

//--- fpu_misc/fp_sign_class.sv
// combinational sign injection, FCLASS and register moves, no flags raised
// sign injection takes raw bits as they are, an unboxed single is not canonicalised
`timescale 1ns/1ps

module fp_sign_class import fp_format_pkg::*, fpu_ctrl_pkg::*; (
	input  fp_unpacked_t a,
	input  fp_word_t     raw_a,
	input  fp_word_t     raw_b,
	input  xlen_word_t   int_in,
	input  fp_fmt_t      fmt,
	input  logic [2:0]   sub,
	input  fpu_op_t      op,
	input  logic         from_int,
	output fp_word_t     value
);

	logic     sign_a;
	logic     sign_b;
	logic     sign_new;
	fp_word_t sgn_value;
	fp_word_t mv_value;

	assign sign_a = (fmt == FMT_D) ? raw_a[D_SIGN_POS] : raw_a[S_SIGN_POS];
	assign sign_b = (fmt == FMT_D) ? raw_b[D_SIGN_POS] : raw_b[S_SIGN_POS];

	always_comb begin
		case (sub)
			SUB_SGNJN: sign_new = ~sign_b;
			SUB_SGNJX: sign_new = sign_a ^ sign_b;
			default:   sign_new = sign_b;	// FSGNJ
		endcase
	end

	// magnitude always from raw_a, singles come out boxed
	assign sgn_value = (fmt == FMT_D) ? {sign_new, raw_a[D_SIGN_POS-1:0]} :
		{{(D_SIGN_POS+1-BOX_LSB){1'b1}}, sign_new, raw_a[S_SIGN_POS-1:0]};

	always_comb begin
		if (from_int) begin
			if (fmt == FMT_D)
				mv_value = int_in;
			else
				mv_value = {{(D_SIGN_POS+1-BOX_LSB){1'b1}}, int_in[S_SIGN_POS:0]};
		end else begin
			if (fmt == FMT_D)
				mv_value = raw_a;
			else	// FMV.X.W sign-extends to xlen
				mv_value = {{(D_SIGN_POS+1-BOX_LSB){raw_a[S_SIGN_POS]}}, raw_a[S_SIGN_POS:0]};
		end
	end

	always_comb begin
		case (op)
			OP_SGN:   value = sgn_value;
			OP_CLASS: value = {{(D_SIGN_POS+1-CLS_W){1'b0}}, a.cls};
			OP_MV:    value = mv_value;
			default:  value = '0;
		endcase
	end

endmodule

//--- fpu_misc/fp_compare.sv
// combinational FLE/FLT/FEQ and FMIN/FMAX on two unpacked operands of one format
// both operands must come from the same fmt, mixed formats are not ordered
`timescale 1ns/1ps

module fp_compare import fp_format_pkg::*, fpu_ctrl_pkg::*; (
	input  fp_unpacked_t a,
	input  fp_unpacked_t b,
	input  fp_word_t     raw_a,
	input  fp_word_t     raw_b,
	input  fp_fmt_t      fmt,
	input  logic [2:0]   sub,
	input  logic         is_minmax,
	output fp_word_t     value,
	output fp_flags_t    flags
);

	logic     nan_a;
	logic     nan_b;
	logic     snan_any;
	logic     zero_a;
	logic     zero_b;
	logic     both_zero;
	logic [D_EXP_W+D_MAN_W-1:0] mag_a;
	logic [D_EXP_W+D_MAN_W-1:0] mag_b;
	logic     eq;
	logic     lt;	// a < b
	logic     cmp_bit;
	logic     a_first;	// a is the smaller one for min/max
	fp_word_t canon_nan;

	assign nan_a    = a.cls[CLS_SNAN] | a.cls[CLS_QNAN];
	assign nan_b    = b.cls[CLS_SNAN] | b.cls[CLS_QNAN];
	assign snan_any = a.cls[CLS_SNAN] | b.cls[CLS_SNAN];
	assign zero_a   = a.cls[CLS_NEG_ZERO] | a.cls[CLS_POS_ZERO];
	assign zero_b   = b.cls[CLS_NEG_ZERO] | b.cls[CLS_POS_ZERO];

	assign canon_nan = (fmt == FMT_D) ? CANON_NAN_D : CANON_NAN_S;

	// ordering is meaningless when a NaN is present, callers mask it
	assign both_zero = zero_a && zero_b;
	assign mag_a = {a.exp, a.man};
	assign mag_b = {b.exp, b.man};

	assign eq = both_zero || ((a.sign == b.sign) && (mag_a == mag_b));	// +0 == -0

	// infinities have the largest exponent, so they land at the ends here
	assign lt = !both_zero && ((a.sign != b.sign) ? a.sign :
		(a.sign ? (mag_b < mag_a) : (mag_a < mag_b)));

	always_comb begin
		case (sub)
			SUB_LE:  cmp_bit = eq | lt;
			SUB_LT:  cmp_bit = lt;
			SUB_EQ:  cmp_bit = eq;
			default: cmp_bit = 1'b0;
		endcase
		if (nan_a || nan_b)
			cmp_bit = 1'b0;	// unordered
	end

	// equal zeros fall back on a's sign, which puts -0 below +0
	assign a_first = eq ? a.sign : lt;

	always_comb begin
		flags = '0;
		if (is_minmax) begin
			flags.nv = snan_any;
			case ({nan_a, nan_b})
				2'b11:   value = canon_nan;
				2'b10:   value = raw_b;
				2'b01:   value = raw_a;
				default: value = (a_first ^ (sub == SUB_MAX)) ? raw_a : raw_b;
			endcase
		end else begin
			// FEQ is quiet, FLT and FLE signal on any NaN
			flags.nv = (sub == SUB_EQ) ? snan_any : (nan_a | nan_b);
			value = {{D_SIGN_POS{1'b0}}, cmp_bit};
		end
	end

	a_eq_lt_excl: assert final ($isunknown({a, b}) || !(eq && lt))
		else $error("fp_compare: operands ordered as both equal and less-than");

endmodule

//--- fpu_misc/fp_unpack.sv
// purely combinational operand decode
// a single whose upper half is not all ones is treated as a quiet NaN
`timescale 1ns/1ps

module fp_unpack import fp_format_pkg::*; (
	input  fp_word_t     value,
	input  fp_fmt_t      fmt,
	output fp_unpacked_t opnd
);

	logic               boxed;
	logic               sign;
	logic [S_EXP_W-1:0] s_exp;
	logic [D_EXP_W-1:0] exp_w;
	logic [D_MAN_W-1:0] man_w;
	logic               exp_zero;
	logic               exp_ones;
	logic               man_zero;
	logic               is_nan;
	fp_class_t          cls;

	assign boxed = (fmt == FMT_D) || (&value[D_SIGN_POS:BOX_LSB]);
	assign s_exp = value[S_SIGN_POS-1 -: S_EXP_W];

	always_comb begin
		if (fmt == FMT_S) begin
			sign = value[S_SIGN_POS];
			// rebias 127 -> 1023, keeps the order of single exponents
			exp_w = {s_exp[S_EXP_W-1], {(D_EXP_W-S_EXP_W){~s_exp[S_EXP_W-1]}},
				s_exp[S_EXP_W-2:0]};
			man_w = {value[S_MAN_W-1:0], {(D_MAN_W-S_MAN_W){1'b0}}};
			exp_zero = (s_exp == '0);
			exp_ones = &s_exp;
		end else begin
			sign = value[D_SIGN_POS];
			exp_w = value[D_SIGN_POS-1 -: D_EXP_W];
			man_w = value[D_MAN_W-1:0];
			exp_zero = (exp_w == '0);
			exp_ones = (exp_w == D_EXP_ONES);
		end
		man_zero = (man_w == '0);
	end

	assign is_nan = exp_ones && !man_zero;

	// each class bit decoded on its own
	always_comb begin
		cls[CLS_QNAN]     = !boxed || (is_nan && man_w[D_MAN_W-1]);	// quiet bit is fraction msb
		cls[CLS_SNAN]     = boxed && is_nan && !man_w[D_MAN_W-1];
		cls[CLS_NEG_INF]  = boxed && exp_ones && man_zero && sign;
		cls[CLS_POS_INF]  = boxed && exp_ones && man_zero && !sign;
		cls[CLS_NEG_ZERO] = boxed && exp_zero && man_zero && sign;
		cls[CLS_POS_ZERO] = boxed && exp_zero && man_zero && !sign;
		cls[CLS_NEG_SUB]  = boxed && exp_zero && !man_zero && sign;
		cls[CLS_POS_SUB]  = boxed && exp_zero && !man_zero && !sign;
		cls[CLS_NEG_NORM] = boxed && !exp_zero && !exp_ones && sign;
		cls[CLS_POS_NORM] = boxed && !exp_zero && !exp_ones && !sign;
	end

	assign opnd = {sign, exp_w, man_w, cls};

	// operands are X until the first issue
	a_cls_onehot: assert final ($isunknown({value, fmt}) || $onehot(opnd.cls))
		else $error("fp_unpack: class of a known operand is not one-hot");

endmodule

//--- common/fpu_ctrl_pkg.sv
// command and result encodings of the single-cycle FP ops
// op numbers match the full FPU decode so the other engines can share it
package fpu_ctrl_pkg;

	import fp_format_pkg::*;

	localparam int TAG_W_DEFAULT = 5;	// destination register tag

	typedef logic [63:0] xlen_word_t;

	typedef enum logic [3:0] {
		OP_SGN    = 4'd5,
		OP_MINMAX = 4'd6,
		OP_CMP    = 4'd12,
		OP_CLASS  = 4'd13,
		OP_MV     = 4'd14
	} fpu_op_t;

	// sub field, taken from the rm bits of the instruction
	localparam logic [2:0] SUB_SGNJ  = 3'd0;
	localparam logic [2:0] SUB_SGNJN = 3'd1;
	localparam logic [2:0] SUB_SGNJX = 3'd2;
	localparam logic [2:0] SUB_MIN   = 3'd0;
	localparam logic [2:0] SUB_MAX   = 3'd1;
	localparam logic [2:0] SUB_LE    = 3'd0;
	localparam logic [2:0] SUB_LT    = 3'd1;
	localparam logic [2:0] SUB_EQ    = 3'd2;

	typedef struct packed {
		fpu_op_t                  op;
		fp_fmt_t                  fmt;
		logic [2:0]               sub;
		logic                     from_int;	// FMV.W/D.X when set
		logic [TAG_W_DEFAULT-1:0] rd;
	} fpu_cmd_t;

	// fflags order
	typedef struct packed {
		logic nv;
		logic dz;
		logic of;
		logic uf;
		logic nx;
	} fp_flags_t;

	typedef struct packed {
		logic                     valid;
		fp_word_t                 value;
		logic [TAG_W_DEFAULT-1:0] rd;
		logic                     writes_fp;	// FP file, else integer file
		fp_flags_t                flags;
	} fpu_result_t;

endpackage

//--- common/fp_format_pkg.sv
// single precision values sit NaN-boxed in the low half of a 64-bit register
// unpacked exponents carry the double bias so one comparator serves both formats
package fp_format_pkg;

	typedef logic [63:0] fp_word_t;

	typedef enum logic {
		FMT_S = 1'b0,
		FMT_D = 1'b1
	} fp_fmt_t;

	// field layout
	localparam int S_EXP_W    = 8;
	localparam int S_MAN_W    = 23;
	localparam int S_SIGN_POS = 31;
	localparam int D_EXP_W    = 11;
	localparam int D_MAN_W    = 52;
	localparam int D_SIGN_POS = 63;
	localparam int BOX_LSB    = 32;	// bits 63:32 must be ones for a valid single

	localparam logic [D_EXP_W-1:0] D_EXP_ONES = 11'h7ff;

	// canonical quiet NaNs, single already boxed
	localparam fp_word_t CANON_NAN_S = 64'hffff_ffff_7fc0_0000;
	localparam fp_word_t CANON_NAN_D = 64'h7ff8_0000_0000_0000;

	// FCLASS bit positions
	localparam int CLS_NEG_INF  = 0;
	localparam int CLS_NEG_NORM = 1;
	localparam int CLS_NEG_SUB  = 2;
	localparam int CLS_NEG_ZERO = 3;
	localparam int CLS_POS_ZERO = 4;
	localparam int CLS_POS_SUB  = 5;
	localparam int CLS_POS_NORM = 6;
	localparam int CLS_POS_INF  = 7;
	localparam int CLS_SNAN     = 8;
	localparam int CLS_QNAN     = 9;

	localparam int CLS_W = 10;

	typedef logic [CLS_W-1:0] fp_class_t;	// one-hot, FCLASS order

	// decoded operand
	// man is left-aligned, so single fractions fill the top 23 bits
	typedef struct packed {
		logic               sign;
		logic [D_EXP_W-1:0] exp;
		logic [D_MAN_W-1:0] man;
		fp_class_t          cls;
	} fp_unpacked_t;

endpackage
